//--- design/rob_commit_pkg.sv
// Reorder buffer commit package
// Operation word layout, system function codes and commit limits

package rob_commit_pkg;

	// ====================
	// Operation word
	// ====================

	// Compute format, class in the top nibble and operand fields below it
	typedef struct packed {
		logic [3:0]  op_class;
		logic [11:0] operands;
	} alu_fmt_t;

	// System format shares the class nibble and carries a function code
	typedef struct packed {
		logic [3:0] op_class;
		logic [3:0] sys_fn;
		logic [7:0] spare;
	} sys_fmt_t;

	// One dispatched word, read either as a compute or as a system op
	typedef union packed {
		alu_fmt_t alu_fmt;
		sys_fmt_t sys_fmt;
	} op_word_u;

	// Class value that selects the system view
	localparam logic [3:0] OP_CLASS_SYS = 4'hF;

	// System functions that must retire alone at the end of a group
	localparam logic [3:0] SYS_FN_CSR = 4'h1;
	localparam logic [3:0] SYS_FN_RTE = 4'h2;

	// ====================
	// Commit
	// ====================

	// Checkpoint index attached to every entry
	typedef logic [1:0] cndx_t;

	// Size of the head window and width of the commit count
	localparam int MAX_COMMIT_WIDTH = 4;
	localparam int CMTCNT_W = 3;

endpackage

//--- design/rob_view_if.sv
// Reorder buffer status view
// Per-entry status vectors from the entry storage to the commit counter

`timescale 1ns/1ps

interface rob_view_if
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16
);

	// One bit per entry for each status field
	logic [ROB_DEPTH-1:0] v;
	logic [ROB_DEPTH-1:0] done;
	logic [ROB_DEPTH-1:0] oddball;
	logic [ROB_DEPTH-1:0] excv;
	logic [ROB_DEPTH-1:0] nan;

	// Checkpoint index of each entry
	cndx_t [ROB_DEPTH-1:0] cndx;

	// The storage side owns every field
	modport store (
		output v,
		output done,
		output oddball,
		output excv,
		output nan,
		output cndx
	);

	// The commit counter only looks
	modport reader (
		input v,
		input done,
		input oddball,
		input excv,
		input nan,
		input cndx
	);

endinterface

//--- design/rob_table.sv
// Reorder buffer entry storage
// Written at dispatch, marked at completion, released at commit

`timescale 1ns/1ps

module rob_table
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                disp_valid,
	input  op_word_u            disp_op,
	input  cndx_t               disp_cndx,
	input  logic [TAG_W-1:0]    tail,
	input  logic                rob_full,
	input  logic                cmpl_valid,
	input  logic [TAG_W-1:0]    cmpl_tag,
	input  logic                cmpl_exc,
	input  logic                cmpl_nan,
	input  logic [TAG_W-1:0]    head,
	input  logic [CMTCNT_W-1:0] cmtcnt,
	input  logic                do_commit,
	rob_view_if.store           view
);

	// Valid bits are the only control state in the table
	logic [ROB_DEPTH-1:0] v_q;

	// Payload, rewritten at every dispatch
	logic [ROB_DEPTH-1:0] done_q;
	logic [ROB_DEPTH-1:0] oddball_q;
	logic [ROB_DEPTH-1:0] excv_q;
	logic [ROB_DEPTH-1:0] nan_q;
	cndx_t [ROB_DEPTH-1:0] cndx_q;

	logic disp_ok;
	logic disp_oddball;

	// A dispatch into a full buffer is dropped
	assign disp_ok = disp_valid && !rob_full;

	// Class is read through the compute view, the function through the system view
	assign disp_oddball = (disp_op.alu_fmt.op_class == OP_CLASS_SYS) &&
		((disp_op.sys_fmt.sys_fn == SYS_FN_CSR) ||
		(disp_op.sys_fmt.sys_fn == SYS_FN_RTE));

	always_ff @(posedge clk) begin
		if (rst) begin
			v_q <= '0;
		end else begin
			// Release the committed run starting at head
			if (do_commit) begin
				for (int k = 0; k < MAX_COMMIT_WIDTH; k++) begin
					if (CMTCNT_W'(k) < cmtcnt)
						v_q[head + TAG_W'(k)] <= 1'b0;
				end
			end
			// Tail always points at a free slot while the buffer is not full
			if (disp_ok)
				v_q[tail] <= 1'b1;
		end
	end

	// Payload write and completion update
	always_ff @(posedge clk) begin
		if (disp_ok) begin
			done_q[tail]    <= 1'b0;
			excv_q[tail]    <= 1'b0;
			nan_q[tail]     <= 1'b0;
			oddball_q[tail] <= disp_oddball;
			cndx_q[tail]    <= disp_cndx;
		end
		// Completion lands on an older entry, never on the one being written
		if (cmpl_valid) begin
			done_q[cmpl_tag] <= 1'b1;
			excv_q[cmpl_tag] <= cmpl_exc;
			nan_q[cmpl_tag]  <= cmpl_nan;
		end
	end

	// Status reads as zero for any free slot
	assign view.v       = v_q;
	assign view.done    = v_q & done_q;
	assign view.oddball = v_q & oddball_q;
	assign view.excv    = v_q & excv_q;
	assign view.nan     = v_q & nan_q;

	for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_cndx
		assign view.cndx[i] = v_q[i] ? cndx_q[i] : cndx_t'(0);
	end

	// Execution units only report tags that were handed out and not yet retired
	a_cmpl_valid_entry: assert property (@(posedge clk) disable iff (rst)
		cmpl_valid |-> v_q[cmpl_tag]);

endmodule

//--- design/head_tracker.sv
// Reorder buffer pointer tracker
// Head and tail pointers, occupancy and the full flag

`timescale 1ns/1ps

module head_tracker
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int COMMIT_WIDTH = 4,
	localparam int TAG_W = $clog2(ROB_DEPTH),
	localparam int CNT_W = $clog2(ROB_DEPTH + 1)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                disp_valid,
	input  logic                do_commit,
	input  logic [CMTCNT_W-1:0] cmtcnt,
	output logic [TAG_W-1:0]    head,
	output logic [TAG_W-1:0]    tail,
	output logic                rob_full
);

	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] retire_n;
	logic             disp_ok;

	// Same drop rule as the storage side
	assign disp_ok = disp_valid && !rob_full;

	// Entries leaving the buffer this cycle
	assign retire_n = do_commit ? CNT_W'(cmtcnt) : '0;

	// Depth is a power of two, so the pointers wrap on their own
	always_ff @(posedge clk) begin
		if (rst) begin
			head    <= '0;
			tail    <= '0;
			count_q <= '0;
		end else begin
			if (do_commit)
				head <= head + TAG_W'(cmtcnt);
			if (disp_ok)
				tail <= tail + 1'b1;
			// Occupancy moves by the dispatch minus the retired count
			count_q <= count_q + CNT_W'(disp_ok) - retire_n;
		end
	end

	assign rob_full = (count_q == CNT_W'(ROB_DEPTH));

	// The counter never retires more than is held
	a_cmt_le_count: assert property (@(posedge clk) disable iff (rst)
		do_commit |-> (CNT_W'(cmtcnt) <= count_q));

	// Group size stays within the configured width
	a_cmt_le_width: assert property (@(posedge clk) disable iff (rst)
		int'(cmtcnt) <= COMMIT_WIDTH);

endmodule

//--- design/commit_count.sv
// Reorder buffer commit counter
// Sizes the next commit group at head and reports it as a registered pulse

`timescale 1ns/1ps

module commit_count
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int COMMIT_WIDTH = 4,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                clk,
	input  logic                rst,
	rob_view_if.reader          view,
	input  logic [TAG_W-1:0]    head,
	output logic [CMTCNT_W-1:0] cmtcnt,
	output logic                do_commit
);

	// ====================
	// Head window
	// ====================

	logic [TAG_W-1:0] slot_idx [MAX_COMMIT_WIDTH];
	logic [MAX_COMMIT_WIDTH-1:0] slot_rdy;
	logic [MAX_COMMIT_WIDTH-1:0] slot_stop;
	logic [MAX_COMMIT_WIDTH-1:0] slot_nan;
	logic [MAX_COMMIT_WIDTH-1:0] slot_same_cp;
	logic [MAX_COMMIT_WIDTH-1:0] elig;
	logic [CMTCNT_W-1:0]         win_cnt;

	// Slot k is the entry k places after head and wraps around the buffer
	for (genvar k = 0; k < MAX_COMMIT_WIDTH; k++) begin : g_slot
		assign slot_idx[k]     = head + TAG_W'(k);
		assign slot_rdy[k]     = view.v[slot_idx[k]] && view.done[slot_idx[k]];
		// An oddball or excepting entry closes the group after itself
		assign slot_stop[k]    = view.oddball[slot_idx[k]] || view.excv[slot_idx[k]];
		assign slot_nan[k]     = view.nan[slot_idx[k]];
		assign slot_same_cp[k] = (view.cndx[slot_idx[k]] == view.cndx[slot_idx[0]]);
	end

	// ====================
	// Eligibility
	// ====================

	always_comb begin : elig_calc
		logic stop_seen;
		logic nan_seen;
		stop_seen = 1'b0;
		nan_seen  = 1'b0;
		for (int k = 0; k < MAX_COMMIT_WIDTH; k++) begin
			// Eligible slots are ready and share the checkpoint of slot 0
			// They may not follow a stopper or be a second NaN
			elig[k] = (k < COMMIT_WIDTH) && slot_rdy[k] && slot_same_cp[k] &&
				!stop_seen && !(nan_seen && slot_nan[k]);
			stop_seen = stop_seen || slot_stop[k];
			nan_seen  = nan_seen || slot_nan[k];
		end
	end

	// Count the unbroken run of eligible slots from slot 0
	always_comb begin : lead_count
		logic run;
		run     = 1'b1;
		win_cnt = '0;
		for (int k = 0; k < MAX_COMMIT_WIDTH; k++) begin
			run = run && elig[k];
			if (run)
				win_cnt = CMTCNT_W'(k + 1);
		end
	end

	// ====================
	// Registered result
	// ====================

	// While a pulse is out the head has not moved yet, so the window is stale
	always_ff @(posedge clk) begin
		if (rst) begin
			cmtcnt    <= '0;
			do_commit <= 1'b0;
		end else if (do_commit) begin
			cmtcnt    <= '0;
			do_commit <= 1'b0;
		end else begin
			cmtcnt    <= win_cnt;
			// A group exists whenever the oldest entry can retire
			do_commit <= elig[0];
		end
	end

	// The pulse and a nonzero count always travel together
	a_pulse_has_count: assert property (@(posedge clk) disable iff (rst)
		do_commit == (cmtcnt != '0));

endmodule

//--- design/rob_commit_top.sv
// Reorder buffer commit stage
// Entry storage, pointer tracking and the commit counter

`timescale 1ns/1ps

module rob_commit_top
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int COMMIT_WIDTH = 4,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                disp_valid,
	input  logic [15:0]         disp_op,
	input  cndx_t               disp_cndx,
	input  logic                cmpl_valid,
	input  logic [TAG_W-1:0]    cmpl_tag,
	input  logic                cmpl_exc,
	input  logic                cmpl_nan,
	output logic [TAG_W-1:0]    disp_tag,
	output logic                rob_full,
	output logic [CMTCNT_W-1:0] cmtcnt,
	output logic                do_commit
);

	logic [TAG_W-1:0] head;

	// Status vectors from storage to the counter
	rob_view_if #(.ROB_DEPTH(ROB_DEPTH)) u_view ();

	rob_table #(
		.ROB_DEPTH(ROB_DEPTH)
	) u_table (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.disp_op    (disp_op),
		.disp_cndx  (disp_cndx),
		.tail       (disp_tag),
		.rob_full   (rob_full),
		.cmpl_valid (cmpl_valid),
		.cmpl_tag   (cmpl_tag),
		.cmpl_exc   (cmpl_exc),
		.cmpl_nan   (cmpl_nan),
		.head       (head),
		.cmtcnt     (cmtcnt),
		.do_commit  (do_commit),
		.view       (u_view.store)
	);

	// The tail pointer doubles as the tag of the next dispatch
	head_tracker #(
		.ROB_DEPTH    (ROB_DEPTH),
		.COMMIT_WIDTH (COMMIT_WIDTH)
	) u_ptrs (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.do_commit  (do_commit),
		.cmtcnt     (cmtcnt),
		.head       (head),
		.tail       (disp_tag),
		.rob_full   (rob_full)
	);

	commit_count #(
		.ROB_DEPTH    (ROB_DEPTH),
		.COMMIT_WIDTH (COMMIT_WIDTH)
	) u_cmt (
		.clk        (clk),
		.rst        (rst),
		.view       (u_view.reader),
		.head       (head),
		.cmtcnt     (cmtcnt),
		.do_commit  (do_commit)
	);

endmodule

//--- verification/commit_checker.sv
// Commit group checker
// Records every commit pulse and compares the groups of a test with the expected list

`timescale 1ns/1ps

module commit_checker
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                do_commit,
	input  logic [CMTCNT_W-1:0] cmtcnt,
	input  logic                rob_full,
	input  logic [TAG_W-1:0]    disp_tag,
	input  logic                test_end,
	input  int                  test_id,
	input  logic [31:0]         exp_groups,
	input  logic                exp_full,
	output int                  pass_count,
	output int                  fail_count
);

	// Group sizes seen since the last test ended with the oldest first
	int   got_q [$];
	logic full_seen;

	// Expected tag of the next dispatch when the current test began
	int   tail_base;

	// Every accepted entry takes the next tag and retires in one of the groups
	function automatic int expected_tail();
		int n_exp;
		int sum;
		n_exp = int'(exp_groups[31:28]);
		sum   = tail_base;
		for (int i = 0; i < n_exp; i++)
			sum += int'(exp_groups[27 - 4*i -: 4]);
		return sum % ROB_DEPTH;
	endfunction

	// Returns an empty string for a matching test and otherwise what went wrong
	function automatic string group_mismatch();
		int n_exp;
		int exp_size;
		n_exp = int'(exp_groups[31:28]);
		if (full_seen != exp_full)
			return $sformatf("full flag seen %0b, expected %0b", full_seen, exp_full);
		if (got_q.size() != n_exp)
			return $sformatf("%0d commit groups, expected %0d", got_q.size(), n_exp);
		// Sizes sit in nibbles below the count with the first group highest
		for (int i = 0; i < n_exp; i++) begin
			exp_size = int'(exp_groups[27 - 4*i -: 4]);
			if (got_q[i] != exp_size)
				return $sformatf("group %0d has %0d entries, expected %0d",
					i, got_q[i], exp_size);
		end
		if (int'(disp_tag) != expected_tail())
			return $sformatf("next tag %0d, expected %0d", disp_tag, expected_tail());
		return "";
	endfunction

	// Outputs settle after the rising edge, so they are read on the falling one
	always @(negedge clk) begin : watch
		string msg;
		if (rst) begin
			got_q.delete();
			full_seen  = 1'b0;
			tail_base  = 0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			if (do_commit)
				got_q.push_back(int'(cmtcnt));
			if (rob_full)
				full_seen = 1'b1;
			if (test_end) begin
				msg = group_mismatch();
				if (msg == "") begin
					pass_count++;
					$display("PASS test %0d", test_id);
				end else begin
					fail_count++;
					$display("FAIL %0t: test %0d, %s", $time, test_id, msg);
				end
				tail_base = expected_tail();
				got_q.delete();
				full_seen = 1'b0;
			end
		end
	end

endmodule

//--- verification/tb_rob_commit.sv
// Reorder buffer commit testbench
// Runs the tests of the data file through the commit stage and reports the result

`timescale 1ns/1ps

module tb_rob_commit
	import rob_commit_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int COMMIT_WIDTH = 4
) ();

	localparam int TAG_W = $clog2(ROB_DEPTH);
	localparam int MEM_WORDS = 256;
	localparam int CYCLES_PER_TEST = 64;

	logic                clk;
	logic                rst;
	logic                disp_valid;
	logic [15:0]         disp_op;
	cndx_t               disp_cndx;
	logic                cmpl_valid;
	logic [TAG_W-1:0]    cmpl_tag;
	logic                cmpl_exc;
	logic                cmpl_nan;
	logic [TAG_W-1:0]    disp_tag;
	logic                rob_full;
	logic [CMTCNT_W-1:0] cmtcnt;
	logic                do_commit;

	// End of test strobe and the expected values that go with it
	logic        test_end;
	int          test_id;
	logic [31:0] exp_groups;
	logic        exp_full;
	int          pass_count;
	int          fail_count;

	logic [31:0] test_mem [MEM_WORDS];
	int          n_tests;
	int          cycle_limit;
	int          cycles;
	int          committed;

	rob_commit_top #(
		.ROB_DEPTH    (ROB_DEPTH),
		.COMMIT_WIDTH (COMMIT_WIDTH)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.disp_op    (disp_op),
		.disp_cndx  (disp_cndx),
		.cmpl_valid (cmpl_valid),
		.cmpl_tag   (cmpl_tag),
		.cmpl_exc   (cmpl_exc),
		.cmpl_nan   (cmpl_nan),
		.disp_tag   (disp_tag),
		.rob_full   (rob_full),
		.cmtcnt     (cmtcnt),
		.do_commit  (do_commit)
	);

	commit_checker #(
		.ROB_DEPTH  (ROB_DEPTH)
	) u_checker (
		.clk        (clk),
		.rst        (rst),
		.do_commit  (do_commit),
		.cmtcnt     (cmtcnt),
		.rob_full   (rob_full),
		.disp_tag   (disp_tag),
		.test_end   (test_end),
		.test_id    (test_id),
		.exp_groups (exp_groups),
		.exp_full   (exp_full),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// Run limit
	// ====================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the buffer did not drain within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	// Running total of retired entries that tells when the buffer is empty
	always @(negedge clk) begin
		if (rst)
			committed <= 0;
		else if (do_commit)
			committed <= committed + int'(cmtcnt);
	end

	// ====================
	// Drivers
	// ====================

	// One dispatch that reports whether the buffer took it and under which tag
	task automatic dispatch_one(input logic [31:0] word, output logic took,
		output logic [TAG_W-1:0] tag);
		@(posedge clk);
		disp_valid <= 1'b1;
		disp_op    <= word[23:8];
		disp_cndx  <= word[5:4];
		// Full flag and tail hold here until the edge that samples the dispatch
		@(negedge clk);
		took = !rob_full;
		tag  = disp_tag;
	endtask

	// Flags nibble carries exc in bit 1 and nan in bit 0
	task automatic complete_one(input logic [TAG_W-1:0] tag, input logic [3:0] flags);
		@(posedge clk);
		cmpl_valid <= 1'b1;
		cmpl_tag   <= tag;
		cmpl_exc   <= flags[1];
		cmpl_nan   <= flags[0];
	endtask

	task automatic idle_inputs();
		@(posedge clk);
		disp_valid <= 1'b0;
		cmpl_valid <= 1'b0;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin : run_tests
		int               ptr;
		int               n_instr;
		int               target;
		logic             took;
		logic [TAG_W-1:0] tag;
		logic [TAG_W-1:0] tag_q [$];
		logic [3:0]       flag_q [$];

		rst        = 1'b1;
		disp_valid = 1'b0;
		disp_op    = '0;
		disp_cndx  = '0;
		cmpl_valid = 1'b0;
		cmpl_tag   = '0;
		cmpl_exc   = 1'b0;
		cmpl_nan   = 1'b0;
		test_end   = 1'b0;
		test_id    = 0;
		exp_groups = '0;
		exp_full   = 1'b0;
		target     = 0;

		// Each record holds the count, the full flag and the groups before the instructions
		$readmemh("verification/rob_commit_tests.txt", test_mem);
		n_tests = 0;
		ptr     = 0;
		while (ptr < MEM_WORDS && test_mem[ptr] != 32'h0) begin
			n_tests++;
			ptr += 3 + int'(test_mem[ptr]);
		end
		cycle_limit = n_tests * CYCLES_PER_TEST;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		ptr = 0;
		for (int t = 0; t < n_tests; t++) begin
			n_instr = int'(test_mem[ptr]);
			tag_q.delete();
			flag_q.delete();
			for (int i = 0; i < n_instr; i++) begin
				dispatch_one(test_mem[ptr + 3 + i], took, tag);
				if (took) begin
					tag_q.push_back(tag);
					flag_q.push_back(test_mem[ptr + 3 + i][3:0]);
				end
			end
			idle_inputs();
			// The youngest completes first so that the oldest entry opens the whole window
			for (int i = tag_q.size() - 1; i >= 0; i--)
				complete_one(tag_q[i], flag_q[i]);
			idle_inputs();
			target += tag_q.size();
			while (committed < target)
				@(posedge clk);
			// Let the lockout cycle after the last pulse pass
			repeat (2) @(posedge clk);
			test_end   <= 1'b1;
			test_id    <= t + 1;
			exp_groups <= test_mem[ptr + 2];
			exp_full   <= test_mem[ptr + 1][0];
			@(posedge clk);
			test_end <= 1'b0;
			ptr += 3 + n_instr;
		end

		repeat (2) @(posedge clk);
		$display("Summary: %0d passed, %0d failed, %0d run", pass_count, fail_count, n_tests);
		if (n_tests > 0 && fail_count == 0 && pass_count == n_tests) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verification/rob_commit_tests.txt
// Per test, in hex: instruction count, expected full flag, expected groups, instructions
// Groups: count in the top nibble, sizes oldest first. Instr: op(16) cndx(4) flags(4)
// Flags bit 1 is exc, bit 0 is nan

// 1. Plain compute ops, some with CSR-like operand bits
08 0 2440_0000 0123_00 1100_00 2200_00 3456_00 4100_00 5abc_00 6200_00 7def_00
// 2. CSR as the second instruction closes the first group
08 0 3242_0000 0111_00 f100_00 0222_00 0333_00 0444_00 0555_00 0666_00 0777_00
// 3. RTE in the same place
08 0 3242_0000 0111_00 f200_00 0222_00 0333_00 0444_00 0555_00 0666_00 0777_00
// 4. Exception on the second instruction
06 0 2240_0000 1010_00 1020_02 1030_00 1040_00 1050_00 1060_00
// 5. Checkpoint changes on the fourth instruction
08 0 3341_0000 2001_00 2002_00 2003_00 2004_10 2005_10 2006_10 2007_10 2008_10
// 6. NaN on the first and third instructions
08 0 3242_0000 3001_01 3002_00 3003_01 3004_00 3005_00 3006_00 3007_00 3008_00
// 7. Seventeen dispatches without completions, the last one is dropped
11 1 4444_4000 0100_00 0101_00 0102_00 0103_00 0104_00 0105_00 0106_00 0107_00 0108_00
0109_00 010a_00 010b_00 010c_00 010d_00 010e_00 010f_00 0110_00
// 8. NaN, a system op that is not oddball, then an exception
05 0 2410_0000 4001_00 4002_01 f300_00 4004_02 4005_00
// End of tests
00

//--- rob_commit_top.f
design/rob_commit_pkg.sv
design/rob_view_if.sv
design/rob_table.sv
design/head_tracker.sv
design/commit_count.sv
design/rob_commit_top.sv
verification/commit_checker.sv
verification/tb_rob_commit.sv

//--- Makefile
# Verilator build and run for the reorder buffer commit stage

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_rob_commit
FILELIST := rob_commit_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := all tests passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
